// File: dv/ncc_chk.sv
`timescale 1ns/10ps

module ncc_chk (
	input logic clk,
	input logic rst_n,
	input logic rd_req,
	input logic wr_en,
	input logic rd_ready,
	input logic flag_we
);

	logic pending;  // read issued, answer not yet back.

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			pending <= 1'b0;
		end else if (rd_req) begin
			pending <= 1'b1;
		end else if (rd_ready) begin
			pending <= 1'b0;
		end
	end

	a_one_read: assert property (@(posedge clk) disable iff (!rst_n) rd_req |-> !pending)
		else $error("rd_req issued while a read is still outstanding");

	a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n) !(rd_req && wr_en))
		else $error("rd_req and wr_en high in the same cycle");

	a_flag_pulse: assert property (@(posedge clk) disable iff (!rst_n) flag_we |=> !flag_we)
		else $error("flag_we held longer than one cycle");

endmodule : ncc_chk

bind user_interface ncc_chk u_chk (
	.clk     (clk),
	.rst_n   (rst_n),
	.rd_req  (mem_cmd.rd_req),
	.wr_en   (mem_cmd.wr_en),
	.rd_ready(rd_ready),
	.flag_we (flag_we)
);

// File: dv/ncc_input.txt
// 4 template words, then 8 windows x 4 words for frame 0 and for frame 1 (memory byte order)
// then per frame: 8 expected scores, best index, best score (plain values)
01020304 05060708 01010101 02000100
01010101 01010101 01010101 01010101 00000000 00000000 00000000 00000000
10203040 00000000 00000000 00000000 00000000 01000000 00000000 00000000
ffffffff ffffffff ffffffff ffffffff 00000000 00000000 ff000000 0000ff00
ffffffff ffffffff ffffffff ffffffff 02030405 00000000 00000000 0a000000
80808080 00000000 00000000 00000000 00000000 80808080 00000000 00000000
00000000 00000000 80808080 80808080 11223344 55667788 00000000 00000000
00000000 00000000 00000000 00000000 01020304 05060708 01010101 02000100
fefefefe 00000000 00000000 00000000 00000000 ff000000 00000000 00000000
0000002b 00000000 000001e0 00000005 00002ad5 000001fe 00002ad5 0000003c
00000004 00002ad5
00000500 00000d00 00000380 00000d8c 00000000 000000d5 000009ec 000004fb
00000003 00000d8c

// File: dv/ncc_tb.sv
`timescale 1ns/10ps

module ncc_tb;
	import ncc_pkg::*;

	localparam int TW = 4;
	localparam int NW = 8;
	localparam int CLK_PERIOD = 100;
	localparam int WATCHDOG_CYCLES = 2 * NW * 2 * TW * 6 + 300;
	localparam int W_OFF = TW;                // windows of frame 0, then frame 1.
	localparam int E_OFF = TW + 2 * NW * TW;  // NW scores, best index, best score per frame.
	localparam logic [ADDR_W-1:0] BIDX_ADDR = RESULT_BASE + ADDR_W'(NW);
	localparam logic [ADDR_W-1:0] BSCORE_ADDR = RESULT_BASE + ADDR_W'(NW + 1);

	logic              clk;
	logic              rst_n;
	logic [DATA_W-1:0] rd_data = '0;
	logic              rd_ready = 1'b0;
	logic [DATA_W-1:0] in_flag = '0;
	mem_cmd_t          mem_cmd;
	logic              flag_we;
	logic [DATA_W-1:0] out_flag;
	best_t             best;

	logic [DATA_W-1:0] stim [0:E_OFF+2*(NW+2)-1];
	logic [DATA_W-1:0] mem [logic [ADDR_W-1:0]];
	logic              host_wr = 1'b0;
	logic [DATA_W-1:0] host_val = '0;
	logic              expect_idle = 1'b1;
	logic [ADDR_W-1:0] frame_base = FRAME_BASE0;
	logic              rd_busy;
	logic              done_seen;
	logic [ADDR_W-1:0] rd_addr;
	int                rd_wait;
	int                res_writes;
	int                val_errs = 0;
	int                proto_errs = 0;

	ncc_top #(.TEMPLATE_WORDS(TW), .NUM_WINDOWS(NW)) UUT (
		.clk, .rst_n, .rd_data, .rd_ready, .in_flag, .mem_cmd, .flag_we, .out_flag, .best
	);

	function automatic logic [DATA_W-1:0] byte_swap(input logic [DATA_W-1:0] d);
		return {d[7:0], d[15:8], d[23:16], d[31:24]};
	endfunction

	function automatic bit in_range(input logic [ADDR_W-1:0] a, input logic [ADDR_W-1:0] base,
		input int n);
		return (a >= base) && (a < base + ADDR_W'(n));
	endfunction

	// template times window, summed over every byte of the file words.
	function automatic score_t window_score(input int frame, input int set);
		logic [DATA_W-1:0] t;
		logic [DATA_W-1:0] w;
		score_t            sum;
		sum = '0;
		for (int i = 0; i < TW; i++) begin
			t = byte_swap(stim[i]);
			w = byte_swap(stim[W_OFF + (frame * NW + set) * TW + i]);
			for (int b = 0; b < 4; b++) begin
				sum += score_t'(t[8*b +: 8]) * score_t'(w[8*b +: 8]);
			end
		end
		return sum;
	endfunction

	task automatic check_score(input string name, input score_t exp, input score_t act);
		if (exp !== act) begin
			$display("Fail %s: expected %0d, got %0d", name, exp, act);
			val_errs++;
		end
	endtask

	task automatic check_best(input string name, input best_t exp, input best_t act);
		if (exp !== act) begin
			$display("Fail %s: expected index %0d score %0d, got index %0d score %0d",
				name, exp.index, exp.score, act.index, act.score);
			val_errs++;
		end
	endtask

	task automatic check_flag(input string name, input logic [DATA_W-1:0] exp,
		input logic [DATA_W-1:0] act);
		if (exp !== act) begin
			$display("Fail %s: expected %h, got %h", name, exp, act);
			val_errs++;
		end
	endtask

	task automatic preload_memory();
		for (int i = 0; i < TW; i++) begin
			mem[TEMPLATE_BASE + ADDR_W'(i)] = stim[i];
		end
		for (int i = 0; i < NW * TW; i++) begin
			mem[FRAME_BASE0 + ADDR_W'(i)] = stim[W_OFF + i];
			mem[FRAME_BASE1 + ADDR_W'(i)] = stim[W_OFF + NW * TW + i];
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// memory model, flag word and bus monitor.
	always @(posedge clk) begin
		rd_ready <= 1'b0;
		if (!rst_n) begin
			rd_busy <= 1'b0;
			done_seen <= 1'b0;
			res_writes <= 0;
			preload_memory();
		end else begin
			if (expect_idle && (mem_cmd.rd_req || mem_cmd.wr_en || flag_we)) begin
				$display("memory or flag access while the controller should be idle");
				proto_errs++;
			end
			if (mem_cmd.rd_req) begin
				if (!in_range(mem_cmd.addr, TEMPLATE_BASE, TW) &&
					!in_range(mem_cmd.addr, frame_base, NW * TW)) begin
					$display("read at %h outside the template and current frame", mem_cmd.addr);
					proto_errs++;
				end
				rd_busy <= 1'b1;
				rd_addr <= mem_cmd.addr;
				rd_wait <= int'($urandom % 4) + 1;  // 1 to 4 cycles.
			end else if (rd_busy) begin
				if (rd_wait == 1) begin
					rd_ready <= 1'b1;
					rd_data <= mem.exists(rd_addr) ? mem[rd_addr] : '0;
					rd_busy <= 1'b0;
				end else begin
					rd_wait <= rd_wait - 1;
				end
			end
			if (mem_cmd.wr_en) begin
				if (done_seen || !in_range(mem_cmd.addr, RESULT_BASE, NW + 2)) begin
					$display("write at %h outside the result area or after done", mem_cmd.addr);
					proto_errs++;
				end
				mem[mem_cmd.addr] = mem_cmd.wdata;
				res_writes <= res_writes + 1;
			end
			if (flag_we) begin
				in_flag <= out_flag;
				if (out_flag == FLAG_ACK) begin
					done_seen <= 1'b0;
					res_writes <= 0;
				end else if (out_flag == FLAG_DONE) begin
					done_seen <= 1'b1;
					if (res_writes != NW + 2) begin
						$display("done posted after %0d of %0d result writes", res_writes, NW + 2);
						proto_errs++;
					end
				end
			end else if (host_wr) begin
				in_flag <= host_val;  // host side of the flag word.
			end
		end
	end

	initial begin
		#(CLK_PERIOD * WATCHDOG_CYCLES);
		$display("watchdog expired after %0d cycles, the runs did not complete", WATCHDOG_CYCLES);
		$display("TESTS FAILED");
		$finish;
	end

	task automatic host_write_flag(input logic [DATA_W-1:0] v);
		@(posedge clk);
		host_val <= v;
		host_wr <= 1'b1;
		@(posedge clk);
		host_wr <= 1'b0;
	endtask

	task automatic run_frame(input int frame);
		best_t  exp_best;
		best_t  mem_best;
		score_t s;
		int     e;
		e = E_OFF + frame * (NW + 2);
		exp_best = '0;
		frame_base = (frame != 0) ? FRAME_BASE1 : FRAME_BASE0;
		host_write_flag(FLAG_START);
		do @(negedge clk); while (!flag_we);
		check_flag($sformatf("frame%0d ack", frame), FLAG_ACK, out_flag);
		do @(negedge clk); while (!flag_we);
		check_flag($sformatf("frame%0d done", frame), FLAG_DONE, out_flag);
		repeat (10) @(negedge clk);  // late writes land in the monitor.
		for (int i = 0; i < NW; i++) begin
			s = window_score(frame, i);
			check_score($sformatf("frame%0d file score %0d", frame, i), stim[e + i], s);
			check_score($sformatf("frame%0d score %0d", frame, i), s,
				byte_swap(mem[RESULT_BASE + ADDR_W'(i)]));
			if (s > exp_best.score) exp_best = '{score: s, index: win_idx_t'(i)};  // earliest wins ties.
		end
		check_best($sformatf("frame%0d file best", frame),
			'{score: stim[e + NW + 1], index: win_idx_t'(stim[e + NW])}, exp_best);
		mem_best.index = win_idx_t'(byte_swap(mem[BIDX_ADDR]));
		mem_best.score = byte_swap(mem[BSCORE_ADDR]);
		check_best($sformatf("frame%0d written best", frame), exp_best, mem_best);
		check_best($sformatf("frame%0d best port", frame), exp_best, best);
	endtask

	initial begin
		void'($urandom(32'h79a6_0acd));
		$readmemh("dv/ncc_input.txt", stim);
		rst_n = 1'b0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		repeat (10) @(posedge clk);  // flag clear, bus must stay quiet.
		expect_idle <= 1'b0;
		run_frame(0);
		run_frame(1);
		$display("summary: %0d value errors, %0d protocol errors", val_errs, proto_errs);
		if (val_errs == 0 && proto_errs == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule : ncc_tb

// File: logic/address_translator.sv
`timescale 1ns/10ps

module address_translator #(
	parameter int TEMPLATE_WORDS = 4
) (
	input  logic                              frame,
	input  logic                              tem_win,  // 0 template, 1 window.
	input  ncc_pkg::win_idx_t                 set,
	input  logic [$clog2(TEMPLATE_WORDS)-1:0] word,
	output logic [ncc_pkg::ADDR_W-1:0]        addr
);
	import ncc_pkg::*;

	localparam logic [ADDR_W-1:0] TW = ADDR_W'(TEMPLATE_WORDS);

	logic [ADDR_W-1:0] base;
	logic [ADDR_W-1:0] set_off;

	always_comb begin
		if (!tem_win) begin
			base = TEMPLATE_BASE;
			set_off = '0;  // a single template for every window.
		end else begin
			base = frame ? FRAME_BASE1 : FRAME_BASE0;
			set_off = ADDR_W'(set) * TW;
		end
		addr = base + set_off + ADDR_W'(word);
	end

endmodule : address_translator

// File: logic/best_window_tracker.sv
`timescale 1ns/10ps

module best_window_tracker (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              trk_clear,
	input  logic              trk_load,
	input  ncc_pkg::score_t   score,
	input  ncc_pkg::win_idx_t set,
	output ncc_pkg::best_t    best
);
	import ncc_pkg::*;

	logic better;

	// strict compare, so a tie keeps the earlier window.
	assign better = score > best.score;

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			best <= '0;
		end else if (trk_clear) begin
			best <= '0;
		end else if (trk_load && better) begin
			best.score <= score;
			best.index <= set;
		end
	end

endmodule : best_window_tracker

// File: logic/correlation_accumulator.sv
`timescale 1ns/10ps

module correlation_accumulator (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       acc_clear,
	input  logic                       acc_step,
	input  logic [ncc_pkg::DATA_W-1:0] tem_word,
	input  logic [ncc_pkg::DATA_W-1:0] win_word,
	output ncc_pkg::score_t            score
);
	import ncc_pkg::*;

	localparam int LANES = DATA_W / 8;

	score_t lane_sum;

	// four byte-lane products of the current word pair.
	always_comb begin
		logic [15:0] prod;
		lane_sum = '0;
		for (int i = 0; i < LANES; i++) begin
			prod = 16'(tem_word[8*i +: 8]) * 16'(win_word[8*i +: 8]);
			lane_sum = lane_sum + score_t'(prod);
		end
	end

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			score <= '0;
		end else if (acc_clear) begin
			score <= '0;  // clear wins over a step.
		end else if (acc_step) begin
			score <= score + lane_sum;
		end
	end

endmodule : correlation_accumulator

// File: logic/ncc_pkg.sv
package ncc_pkg;

	localparam int ADDR_W = 21;
	localparam int DATA_W = 32;

	// flag word protocol with the host.
	localparam logic [DATA_W-1:0] FLAG_START = 32'h0001_0000;
	localparam logic [DATA_W-1:0] FLAG_ACK   = 32'h0000_0002;
	localparam logic [DATA_W-1:0] FLAG_DONE  = 32'h0000_0004;

	// memory map, word addresses.
	localparam logic [ADDR_W-1:0] FLAG_ADDR     = 21'h07_FFFE;
	localparam logic [ADDR_W-1:0] TEMPLATE_BASE = 21'h00_0100;
	localparam logic [ADDR_W-1:0] FRAME_BASE0   = 21'h00_1000;
	localparam logic [ADDR_W-1:0] FRAME_BASE1   = 21'h00_2000;
	localparam logic [ADDR_W-1:0] RESULT_BASE   = 21'h03_CF96;

	typedef logic [31:0] score_t;
	typedef logic [8:0]  win_idx_t;

	// one memory command per cycle, read or write.
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
		logic              rd_req;
		logic              wr_en;
	} mem_cmd_t;

	typedef struct packed {
		score_t   score;
		win_idx_t index;
	} best_t;

endpackage : ncc_pkg

// File: logic/ncc_top.sv
`timescale 1ns/10ps

module ncc_top #(
	parameter int TEMPLATE_WORDS = 4,
	parameter int NUM_WINDOWS    = 8
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic [ncc_pkg::DATA_W-1:0] rd_data,
	input  logic                       rd_ready,
	input  logic [ncc_pkg::DATA_W-1:0] in_flag,
	output ncc_pkg::mem_cmd_t          mem_cmd,
	output logic                       flag_we,
	output logic [ncc_pkg::DATA_W-1:0] out_flag,
	output ncc_pkg::best_t             best
);
	import ncc_pkg::*;

	logic [$clog2(TEMPLATE_WORDS)-1:0] word;
	logic                              tem_win;
	win_idx_t                          set;
	logic                              frame;
	logic [ADDR_W-1:0]                 addr;
	logic                              acc_clear, acc_step;
	logic [DATA_W-1:0]                 tem_word, win_word;
	logic                              trk_clear, trk_load;
	score_t                            score;

	user_interface #(
		.TEMPLATE_WORDS(TEMPLATE_WORDS),
		.NUM_WINDOWS   (NUM_WINDOWS)
	) u_ctrl (
		.clk, .rst_n, .in_flag, .rd_data, .rd_ready, .addr, .score, .best,
		.mem_cmd, .flag_we, .out_flag, .word, .tem_win, .set, .frame,
		.acc_clear, .acc_step, .tem_word, .win_word, .trk_clear, .trk_load
	);

	address_translator #(
		.TEMPLATE_WORDS(TEMPLATE_WORDS)
	) u_xlat (
		.frame, .tem_win, .set, .word, .addr
	);

	correlation_accumulator u_acc (
		.clk, .rst_n, .acc_clear, .acc_step, .tem_word, .win_word, .score
	);

	best_window_tracker u_trk (
		.clk, .rst_n, .trk_clear, .trk_load, .score, .set, .best
	);

endmodule : ncc_top

// File: logic/user_interface.sv
`timescale 1ns/10ps

module user_interface #(
	parameter int TEMPLATE_WORDS = 4,
	parameter int NUM_WINDOWS    = 8
) (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic [ncc_pkg::DATA_W-1:0]            in_flag,
	input  logic [ncc_pkg::DATA_W-1:0]            rd_data,
	input  logic                                  rd_ready,
	input  logic [ncc_pkg::ADDR_W-1:0]            addr,
	input  ncc_pkg::score_t                       score,
	input  ncc_pkg::best_t                        best,
	output ncc_pkg::mem_cmd_t                     mem_cmd,
	output logic                                  flag_we,
	output logic [ncc_pkg::DATA_W-1:0]            out_flag,
	output logic [$clog2(TEMPLATE_WORDS)-1:0]     word,
	output logic                                  tem_win,
	output ncc_pkg::win_idx_t                     set,
	output logic                                  frame,
	output logic                                  acc_clear,
	output logic                                  acc_step,
	output logic [ncc_pkg::DATA_W-1:0]            tem_word,
	output logic [ncc_pkg::DATA_W-1:0]            win_word,
	output logic                                  trk_clear,
	output logic                                  trk_load
);
	import ncc_pkg::*;

	localparam int WORD_W = $clog2(TEMPLATE_WORDS);
	localparam logic [WORD_W-1:0] LAST_WORD = WORD_W'(TEMPLATE_WORDS - 1);
	localparam win_idx_t LAST_SET = win_idx_t'(NUM_WINDOWS - 1);
	localparam logic [ADDR_W-1:0] BIDX_ADDR = RESULT_BASE + ADDR_W'(NUM_WINDOWS);
	localparam logic [ADDR_W-1:0] BSCORE_ADDR = BIDX_ADDR + 21'd1;

	typedef enum logic [3:0] {
		S_IDLE, S_ACK, S_RD_TEM, S_RD_WIN, S_ACCUM,
		S_WR_SCORE, S_WR_BIDX, S_WR_BSCORE, S_DONE
	} state_t;

	state_t cs, ns;
	logic   outstanding;  // a read is in flight.
	logic   armed;        // flag has left the start code since the last run.
	logic   start;

	// memory is big-endian, the datapath works little-endian.
	function automatic logic [DATA_W-1:0] swap(input logic [DATA_W-1:0] d);
		return {d[7:0], d[15:8], d[23:16], d[31:24]};
	endfunction

	assign start = (cs == S_IDLE) && armed && (in_flag == FLAG_START);

	always_comb begin
		ns = cs;
		mem_cmd = '{addr: addr, wdata: '0, rd_req: 1'b0, wr_en: 1'b0};
		flag_we = 1'b0;
		out_flag = '0;
		tem_win = 1'b0;
		acc_clear = 1'b0;
		acc_step = 1'b0;
		trk_clear = 1'b0;
		trk_load = 1'b0;
		case (cs)
			S_IDLE: begin
				if (start) begin
					flag_we = 1'b1;
					out_flag = FLAG_ACK;
					ns = S_ACK;
				end
			end
			S_ACK: begin
				acc_clear = 1'b1;
				trk_clear = 1'b1;
				mem_cmd.rd_req = 1'b1;  // template word 0.
				ns = S_RD_TEM;
			end
			S_RD_TEM: begin
				mem_cmd.rd_req = !outstanding;
				if (rd_ready) ns = S_RD_WIN;
			end
			S_RD_WIN: begin
				tem_win = 1'b1;
				mem_cmd.rd_req = !outstanding;
				if (rd_ready) ns = S_ACCUM;
			end
			S_ACCUM: begin
				acc_step = 1'b1;
				ns = (word == LAST_WORD) ? S_WR_SCORE : S_RD_TEM;
			end
			S_WR_SCORE: begin
				mem_cmd.wr_en = 1'b1;
				mem_cmd.addr = RESULT_BASE + ADDR_W'(set);
				mem_cmd.wdata = swap(score);
				trk_load = 1'b1;
				acc_clear = 1'b1;  // next window starts from zero.
				ns = (set == LAST_SET) ? S_WR_BIDX : S_RD_TEM;
			end
			S_WR_BIDX: begin
				mem_cmd.wr_en = 1'b1;
				mem_cmd.addr = BIDX_ADDR;
				mem_cmd.wdata = swap(DATA_W'(best.index));
				ns = S_WR_BSCORE;
			end
			S_WR_BSCORE: begin
				mem_cmd.wr_en = 1'b1;
				mem_cmd.addr = BSCORE_ADDR;
				mem_cmd.wdata = swap(best.score);
				ns = S_DONE;
			end
			S_DONE: begin
				flag_we = 1'b1;
				out_flag = FLAG_DONE;
				ns = S_IDLE;
			end
			default: ns = S_IDLE;
		endcase
	end

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			cs <= S_IDLE;
			outstanding <= 1'b0;
			armed <= 1'b1;
			frame <= 1'b1;  // first start flips it to buffer 0.
			word <= '0;
			set <= '0;
		end else begin
			cs <= ns;
			if (mem_cmd.rd_req) outstanding <= 1'b1;
			else if (rd_ready) outstanding <= 1'b0;
			if (start) begin
				armed <= 1'b0;
				frame <= ~frame;
				word <= '0;
				set <= '0;
			end else if (in_flag != FLAG_START) begin
				armed <= 1'b1;
			end
			if (cs == S_ACCUM) word <= word + 1'b1;  // wraps after the last word.
			if (cs == S_WR_SCORE && set != LAST_SET) set <= set + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (cs == S_RD_TEM && rd_ready) tem_word <= swap(rd_data);
		if (cs == S_RD_WIN && rd_ready) win_word <= swap(rd_data);
	end

endmodule : user_interface

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line in the log.

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
	--top-module ncc_tb -f verilog.f -Mdir obj_dir -o ncc_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/ncc_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^TESTS PASSED$" "$LOG"; then
	exit 0
fi
exit 1

// File: verilog.f
logic/ncc_pkg.sv
logic/address_translator.sv
logic/correlation_accumulator.sv
logic/best_window_tracker.sv
logic/user_interface.sv
logic/ncc_top.sv
dv/ncc_chk.sv
dv/ncc_tb.sv
